// ==== rs_alu_top.f ====
+incdir+verilog
verilog/rs_pkg.sv
verilog/rs_alloc_ctrl.sv
verilog/rs_entry_array.sv
verilog/rs_wakeup.sv
verilog/rs_issue_select.sv
verilog/rs_alu_top.sv
verification/rs_alu_tb.sv

// ==== Makefile ====
TB_TOP := rs_alu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f rs_alu_top.f --top-module rs_alu_top
	verilator --lint-only --timing --assert -f rs_alu_top.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f rs_alu_top.f --top-module $(TB_TOP) -o rs_alu_sim
	./obj_dir/rs_alu_sim

clean:
	rm -rf obj_dir

// ==== verification/rs_alu_patterns.txt ====
# D inst pc rd op s1sel s2sel imm tag1 tag2 rdy | W bus tag | F | C cycles | N no issue | A full
# E inst pc rd op s1sel s2sel imm tag1 tag2 | U count inst tag | Q count inst tag (all hex)
D 1 1000 05 3 0 1 10 01 02 3
C 1
N
C 1
N
C 1
E 1 1000 05 3 0 1 10 01 02
C 1
N
D 2 1004 06 1 0 0 0 01 20 1
C 1
W 0 21
C 1
C 2
N
W 0 20
C 2
N
C 1
E 2 1004 06 1 0 0 0 01 20
D 3 1008 07 2 1 0 4 31 00 2
C 1
D 4 100c 08 2 1 0 4 32 00 2
C 1
D 5 1010 09 2 1 0 4 33 00 2
C 1
W 1 31
W 2 32
W 3 33
C 2
N
C 1
E 3 1008 07 2 1 0 4 31 00
C 1
E 4 100c 08 2 1 0 4 32 00
C 1
E 5 1010 09 2 1 0 4 33 00
C 1
N
D 6 1014 0a 5 0 0 0 40 02 2
C 1
D 7 1018 0b 6 0 0 0 03 04 3
C 3
E 7 1018 0b 6 0 0 0 03 04
W 0 40
C 3
E 6 1014 0a 5 0 0 0 40 02
D 8 101c 0c 7 1 1 8 50 50 0
W 1 50
C 3
E 8 101c 0c 7 1 1 8 50 50
D 9 1020 0d 8 0 0 0 60 61 0
C 1
F
C 2
W 0 60
W 1 61
C 2
N
C 1
N
A 0
U 10 100 70
C 1
A 1
D 200 2000 20 1 0 0 0 01 02 3
C 3
N
A 1
W 2 70
C 2
Q 10 100 70
N
A 0
U 3 300 80
W 0 80
C 2
Q 3 300 80
N

// ==== verification/rs_alu_tb.sv ====
`default_nettype none

module rs_alu_tb;
    import rs_pkg::*;

    logic      clk;
    logic      rst;
    logic      flush;
    logic      dispatch_valid;
    dispatch_t dispatch;
    logic [1:0] src_ready;
    wake_bus_t wake;
    issue_t    issue;
    logic      full;

    // inputs staged for the next rising edge
    logic      st_dv;
    dispatch_t st_disp;
    logic [1:0] st_rdy;
    wake_bus_t st_wake;
    logic      st_flush;

    rs_alu_top dut (
        .clk(clk), .rst(rst), .flush(flush), .dispatch_valid(dispatch_valid),
        .dispatch(dispatch), .src_ready(src_ready), .wake(wake),
        .issue(issue), .full(full)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_issue(input issue_t got, input issue_t exp);
        if (got !== exp) begin
            $display("** Error: issue got %h expected %h", got, exp);
            fail_run("issue record mismatch");
        end
    endtask

    task automatic check_full(input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error: full got %h expected %h", got, exp);
            fail_run("full level mismatch");
        end
    endtask

    // drive staged inputs at each rising edge and settle on the falling edge
    task automatic step(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            dispatch_valid <= st_dv;
            dispatch       <= st_disp;
            src_ready      <= st_rdy;
            wake           <= st_wake;
            flush          <= st_flush;
            st_dv    = 1'b0;
            st_rdy   = 2'b00;
            st_wake  = '0;
            st_flush = 1'b0;
            @(negedge clk);
        end
    endtask

    function automatic dispatch_t make_dispatch(input logic [31:0] inst, input logic [31:0] pc,
                                               input logic [7:0] rd, input logic [3:0] op,
                                               input logic s1, input logic s2,
                                               input logic [31:0] imm, input logic [7:0] t1,
                                               input logic [7:0] t2);
        dispatch_t d;
        d.inst_num = inst;
        d.pc       = pc;
        d.rd       = rd;
        d.alu_op   = op;
        d.src1_sel = s1;
        d.src2_sel = s2;
        d.imm      = imm;
        d.src1_tag = t1;
        d.src2_tag = t2;
        return d;
    endfunction

    // burst entry with pc = inst*4, rd = low inst byte, imm = inst and both sources on tag
    function automatic dispatch_t burst_entry(input logic [31:0] inst, input logic [7:0] tag);
        return make_dispatch(inst, inst << 2, inst[7:0], 4'h0, 1'b0, 1'b0, inst, tag, tag);
    endfunction

    task automatic wait_reset_done();
        int i;
        i = 0;
        while (!(full === 1'b0 && issue === '0)) begin
            if (i == 20)
                fail_run("buffer did not come out of reset empty");
            @(negedge clk);
            i++;
        end
    endtask

    initial begin
        repeat (5000) @(posedge clk);
        fail_run("timeout, pattern run never finished");
    end

    initial begin
        int         fd;
        int         r;
        int         n;
        int         bus;
        string      line;
        byte        code;
        logic [31:0] a_inst, a_pc, a_imm;
        logic [7:0]  a_rd, a_t1, a_t2;
        logic [3:0]  a_op;
        logic        a_s1, a_s2, a_full;
        logic [1:0]  a_rdy;
        issue_t      exp;

        rst            = 1'b1;
        flush          = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        src_ready      = 2'b00;
        wake           = '0;
        st_dv          = 1'b0;
        st_disp        = '0;
        st_rdy         = 2'b00;
        st_wake        = '0;
        st_flush       = 1'b0;

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        wait_reset_done();

        fd = $fopen("verification/rs_alu_patterns.txt", "r");
        if (fd == 0)
            fail_run("cannot open the pattern file");

        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r == 0)
                break;
            if (line.len() < 1)
                continue;
            code = line.getc(0);
            case (code)
                "D": begin
                    r = $sscanf(line, "D %h %h %h %h %h %h %h %h %h %h", a_inst, a_pc, a_rd,
                                a_op, a_s1, a_s2, a_imm, a_t1, a_t2, a_rdy);
                    st_dv   = 1'b1;
                    st_disp = make_dispatch(a_inst, a_pc, a_rd, a_op, a_s1, a_s2, a_imm,
                                            a_t1, a_t2);
                    st_rdy  = a_rdy;
                end
                "W": begin
                    r = $sscanf(line, "W %h %h", bus, a_t1);
                    st_wake[bus].valid = 1'b1;
                    st_wake[bus].tag   = a_t1;
                end
                "F": st_flush = 1'b1;
                "C": begin
                    r = $sscanf(line, "C %h", n);
                    step(n);
                end
                "E": begin
                    r = $sscanf(line, "E %h %h %h %h %h %h %h %h %h", a_inst, a_pc, a_rd,
                                a_op, a_s1, a_s2, a_imm, a_t1, a_t2);
                    exp.valid = 1'b1;
                    exp.info  = make_dispatch(a_inst, a_pc, a_rd, a_op, a_s1, a_s2, a_imm,
                                              a_t1, a_t2);
                    check_issue(issue, exp);
                end
                "N": check_issue(issue, '0);
                "A": begin
                    r = $sscanf(line, "A %h", a_full);
                    check_full(full, a_full);
                end
                "U": begin
                    r = $sscanf(line, "U %h %h %h", n, a_inst, a_t1);
                    for (int k = 0; k < n; k++) begin
                        st_dv   = 1'b1;
                        st_disp = burst_entry(a_inst + k, a_t1);
                        st_rdy  = 2'b00;
                        step(1);
                    end
                end
                "Q": begin
                    r = $sscanf(line, "Q %h %h %h", n, a_inst, a_t1);
                    step(1);  // burst issues from the next cycle on, one entry per cycle
                    for (int k = 0; k < n; k++) begin
                        exp.valid = 1'b1;
                        exp.info  = burst_entry(a_inst + k, a_t1);
                        check_issue(issue, exp);
                        step(1);
                    end
                end
                default: ;  // comment or blank line
            endcase
        end
        $fclose(fd);

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rs_alu_top.sv ====
`default_nettype none

`include "rs_defs.svh"

module rs_alu_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              dispatch_valid,
    input  rs_pkg::dispatch_t dispatch,
    input  logic [1:0]        src_ready,
    input  rs_pkg::wake_bus_t wake,
    output rs_pkg::issue_t    issue,
    output logic              full
);
    import rs_pkg::*;

    logic                         clear;
    logic                         alloc_en;
    rs_idx_t                      tail;
    rs_idx_t                      head;
    logic [`RS_DEPTH-1:0]         busy;
    logic [`RS_DEPTH-1:0]         ready1;
    logic [`RS_DEPTH-1:0]         ready2;
    logic [`RS_DEPTH-1:0]         set1;
    logic [`RS_DEPTH-1:0]         set2;
    logic [1:0]                   new_ready;
    dispatch_t [`RS_DEPTH-1:0]    entries;
    logic                         issue_fire;
    rs_idx_t                      issue_idx;

    assign clear = rst | flush;  // flush drops everything in flight

    rs_alloc_ctrl u_alloc (
        .clk(clk), .clear(clear), .dispatch_valid(dispatch_valid), .busy(busy),
        .alloc_en(alloc_en), .tail(tail), .head(head), .full(full)
    );

    rs_entry_array u_array (
        .clk(clk), .clear(clear), .alloc_en(alloc_en), .tail(tail),
        .dispatch(dispatch), .new_ready(new_ready), .set1(set1), .set2(set2),
        .issue_fire(issue_fire), .issue_idx(issue_idx),
        .busy(busy), .ready1(ready1), .ready2(ready2), .entries(entries)
    );

    rs_wakeup u_wakeup (
        .entries(entries), .busy(busy), .ready1(ready1), .ready2(ready2),
        .dispatch(dispatch), .src_ready(src_ready), .wake(wake),
        .set1(set1), .set2(set2), .new_ready(new_ready)
    );

    rs_issue_select u_select (
        .clk(clk), .clear(clear), .head(head), .busy(busy), .ready1(ready1),
        .ready2(ready2), .entries(entries), .issue_fire(issue_fire),
        .issue_idx(issue_idx), .issue(issue)
    );

endmodule

`default_nettype wire

// ==== verilog/rs_issue_select.sv ====
`default_nettype none

`include "rs_defs.svh"

module rs_issue_select (
    input  logic                              clk,
    input  logic                              clear,
    input  rs_pkg::rs_idx_t                   head,
    input  logic [`RS_DEPTH-1:0]              busy,
    input  logic [`RS_DEPTH-1:0]              ready1,
    input  logic [`RS_DEPTH-1:0]              ready2,
    input  rs_pkg::dispatch_t [`RS_DEPTH-1:0] entries,
    output logic                              issue_fire,
    output rs_pkg::rs_idx_t                   issue_idx,
    output rs_pkg::issue_t                    issue
);
    import rs_pkg::*;

    logic [`RS_DEPTH-1:0] can_issue;

    assign can_issue = busy & ready1 & ready2;

    // walk from youngest to oldest so the entry nearest head wins
    always_comb begin
        rs_idx_t idx;

        issue_fire = 1'b0;
        issue_idx  = head;
        for (int k = `RS_DEPTH - 1; k >= 0; k--) begin
            idx = head + rs_idx_t'(k);  // wraps with the index width
            if (can_issue[idx]) begin
                issue_fire = 1'b1;
                issue_idx  = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (clear) begin
            issue <= '0;
        end else if (issue_fire) begin
            issue.valid <= 1'b1;
            issue.info  <= entries[issue_idx];
        end else begin
            issue <= '0;  // idle cycles present an all-zero record
        end
    end

    a_issue_from_fire: assert property (@(posedge clk) disable iff (clear)
        issue.valid |-> $past(issue_fire));

endmodule

`default_nettype wire

// ==== verilog/rs_wakeup.sv ====
`default_nettype none

`include "rs_defs.svh"

module rs_wakeup (
    input  rs_pkg::dispatch_t [`RS_DEPTH-1:0] entries,
    input  logic [`RS_DEPTH-1:0]              busy,
    input  logic [`RS_DEPTH-1:0]              ready1,
    input  logic [`RS_DEPTH-1:0]              ready2,
    input  rs_pkg::dispatch_t                 dispatch,
    input  logic [1:0]                        src_ready,
    input  rs_pkg::wake_bus_t                 wake,
    output logic [`RS_DEPTH-1:0]              set1,
    output logic [`RS_DEPTH-1:0]              set2,
    output logic [1:0]                        new_ready
);

    always_comb begin
        set1      = '0;
        set2      = '0;
        new_ready = src_ready;
        for (int b = 0; b < `RS_NUM_WAKE; b++) begin
            if (wake[b].valid) begin
                for (int e = 0; e < `RS_DEPTH; e++) begin
                    if (busy[e] && !ready1[e] && entries[e].src1_tag == wake[b].tag)
                        set1[e] = 1'b1;
                    if (busy[e] && !ready2[e] && entries[e].src2_tag == wake[b].tag)
                        set2[e] = 1'b1;
                end
                // result landing in the dispatch cycle counts as ready
                if (dispatch.src1_tag == wake[b].tag)
                    new_ready[0] = 1'b1;
                if (dispatch.src2_tag == wake[b].tag)
                    new_ready[1] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rs_entry_array.sv ====
`default_nettype none

`include "rs_defs.svh"

module rs_entry_array (
    input  logic                                 clk,
    input  logic                                 clear,
    input  logic                                 alloc_en,
    input  rs_pkg::rs_idx_t                      tail,
    input  rs_pkg::dispatch_t                    dispatch,
    input  logic [1:0]                           new_ready,
    input  logic [`RS_DEPTH-1:0]                 set1,
    input  logic [`RS_DEPTH-1:0]                 set2,
    input  logic                                 issue_fire,
    input  rs_pkg::rs_idx_t                      issue_idx,
    output logic [`RS_DEPTH-1:0]                 busy,
    output logic [`RS_DEPTH-1:0]                 ready1,
    output logic [`RS_DEPTH-1:0]                 ready2,
    output rs_pkg::dispatch_t [`RS_DEPTH-1:0]    entries
);

    // payload is written once at allocation
    always_ff @(posedge clk) begin
        if (alloc_en)
            entries[tail] <= dispatch;
    end

    // busy and per-source ready state
    always_ff @(posedge clk) begin
        if (clear) begin
            busy   <= '0;
            ready1 <= '0;
            ready2 <= '0;
        end else begin
            // wakeup only ever targets busy entries
            ready1 <= ready1 | set1;
            ready2 <= ready2 | set2;

            if (alloc_en) begin
                busy[tail]   <= 1'b1;
                ready1[tail] <= new_ready[0];
                ready2[tail] <= new_ready[1];
            end

            if (issue_fire) begin
                busy[issue_idx]   <= 1'b0;  // slot waits for head to retire it
                ready1[issue_idx] <= 1'b0;
                ready2[issue_idx] <= 1'b0;
            end
        end
    end

    // tail must point past the youngest live entry
    a_alloc_free: assert property (@(posedge clk) disable iff (clear)
        alloc_en |-> !busy[tail]);

    a_issue_busy: assert property (@(posedge clk) disable iff (clear)
        issue_fire |-> busy[issue_idx]);

endmodule

`default_nettype wire

// ==== verilog/rs_alloc_ctrl.sv ====
`default_nettype none

`include "rs_defs.svh"

module rs_alloc_ctrl (
    input  logic                 clk,
    input  logic                 clear,
    input  logic                 dispatch_valid,
    input  logic [`RS_DEPTH-1:0] busy,
    output logic                 alloc_en,
    output rs_pkg::rs_idx_t      tail,
    output rs_pkg::rs_idx_t      head,
    output logic                 full
);

    logic [$clog2(`RS_DEPTH):0] count;  // slots between head and tail
    logic                       retire;

    // a dispatch while full is simply lost
    assign alloc_en = dispatch_valid & ~full;
    // free the head slot in order once its entry has issued
    assign retire   = (count != '0) && !busy[head];
    assign full     = count[$clog2(`RS_DEPTH)];  // msb only set at count == depth

    always_ff @(posedge clk) begin
        if (clear) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (alloc_en)
                tail <= tail + 1'b1;
            if (retire)
                head <= head + 1'b1;
            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (clear)
        count <= ($clog2(`RS_DEPTH) + 1)'(`RS_DEPTH));

endmodule

`default_nettype wire

// ==== verilog/rs_pkg.sv ====
`default_nettype none

`include "rs_defs.svh"

package rs_pkg;

    typedef logic [`RS_TAG_W-1:0]         phys_tag_t;
    typedef logic [`RS_XLEN-1:0]          inst_num_t;
    typedef logic [`RS_XLEN-1:0]          pc_t;
    typedef logic [`RS_XLEN-1:0]          imm_t;
    typedef logic [`RS_ALUOP_W-1:0]       alu_op_t;
    typedef logic [$clog2(`RS_DEPTH)-1:0] rs_idx_t;

    // one instruction as written by dispatch
    typedef struct packed {
        inst_num_t inst_num;
        pc_t       pc;
        phys_tag_t rd;
        alu_op_t   alu_op;
        logic      src1_sel;  // operand selects carried through to the alu
        logic      src2_sel;
        imm_t      imm;
        phys_tag_t src1_tag;
        phys_tag_t src2_tag;
    } dispatch_t;

    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } wake_t;

    // element 3 is the load bus
    typedef wake_t [`RS_NUM_WAKE-1:0] wake_bus_t;

    typedef struct packed {
        logic      valid;
        dispatch_t info;
    } issue_t;

endpackage

`default_nettype wire

// ==== verilog/rs_defs.svh ====
`ifndef RS_DEFS_SVH
`define RS_DEFS_SVH

// dispatch buffer geometry
`define RS_DEPTH    16

// physical register tag
`define RS_TAG_W    8

// result broadcast buses for alu, mul, div and load
`define RS_NUM_WAKE 4

`define RS_XLEN     32  // inst number, pc and immediate
`define RS_ALUOP_W  4

`endif
